//--- hdl/cnn_bus_pkg.sv
`default_nettype none

package cnn_bus_pkg;

	localparam int BUS_ADDR_W = 32;
	localparam int BUS_DATA_W = 32;

	// control registers, matched on the full address
	localparam logic [BUS_ADDR_W-1:0] IMAGE_SET_ADDR = 32'hd111_0000;
	localparam logic [BUS_ADDR_W-1:0] INTR_ADDR      = 32'hd222_0000;

	// memory windows, matched on the upper address half
	localparam logic [BUS_ADDR_W/2-1:0] PIXEL_REGION  = 16'hd555;
	localparam logic [BUS_ADDR_W/2-1:0] WEIGHT_REGION = 16'hd333;

	typedef struct packed {
		logic [BUS_ADDR_W-1:0] awaddr;
		logic                  awvalid;
		logic [BUS_DATA_W-1:0] wdata;
		logic                  wvalid;
	} bus_wr_t;

endpackage

`default_nettype wire

//--- hdl/cnn_load_pkg.sv
`default_nettype none

package cnn_load_pkg;

	localparam int MEM_ADDR_W = 16;
	localparam int MEM_DATA_W = 16;

	typedef struct packed {
		logic                  en;
		logic [MEM_ADDR_W-1:0] addr;
		logic [MEM_DATA_W-1:0] data;
	} mem_wr_t;

	localparam int NUM_WLAYERS = 5;
	localparam int LAYER_ID_W  = 5;

	// entry 0 is the first layer loaded
	localparam logic [NUM_WLAYERS-1:0][LAYER_ID_W-1:0] LAYER_IDS = {
		5'd7, 5'd5, 5'd4, 5'd2, 5'd1
	};

	localparam int L7_BANKS   = 5;
	localparam int BANK_SEL_W = 3;

	// words per layer, same order as LAYER_IDS
	localparam logic [NUM_WLAYERS-1:0][MEM_ADDR_W-1:0] DEF_LAYER_WORDS = {
		16'd2000, 16'd576, 16'd576, 16'd576, 16'd216
	};

	// layer 7 is spread evenly over its banks
	localparam int DEF_L7_BANK_DEPTH = DEF_LAYER_WORDS[NUM_WLAYERS-1] / L7_BANKS;

	// 32x32 image, 3 channels
	localparam int DEF_PIXEL_WORDS = 3072;

endpackage

`default_nettype wire

//--- hdl/bus_write_decoder.sv
`default_nettype none

module bus_write_decoder
	import cnn_bus_pkg::*;
	import cnn_load_pkg::*;
(
	input  bus_wr_t               bus,
	input  logic [1:0]            image_set_q,
	output logic                  pixel_hit,
	output logic                  weight_hit,
	output logic [MEM_DATA_W-1:0] wr_data,
	output logic                  image_set_we,
	output logic [1:0]            image_set_data,
	output logic                  intr_we,
	output logic                  intr_data
);

	logic [BUS_ADDR_W/2-1:0] region;
	logic                    image_set_hit;

	assign region = bus.awaddr[BUS_ADDR_W-1:BUS_ADDR_W/2];

	assign pixel_hit  = bus.wvalid && (region == PIXEL_REGION);
	assign weight_hit = bus.wvalid && (region == WEIGHT_REGION);
	assign wr_data    = bus.wdata[MEM_DATA_W-1:0];

	assign image_set_hit = bus.awvalid && (bus.awaddr == IMAGE_SET_ADDR);

	// a cpu write wins over the auto-clear
	always_comb
	begin
		if (image_set_hit)
		begin
			image_set_we   = 1'b1;
			image_set_data = bus.wdata[1:0];
		end
		else if (image_set_q != 2'b00)
		begin
			image_set_we   = 1'b1;
			image_set_data = 2'b00;
		end
		else
		begin
			image_set_we   = 1'b0;
			image_set_data = 2'b00;
		end
	end

	// any write to the interrupt register acknowledges it
	assign intr_we   = bus.awvalid && (bus.awaddr == INTR_ADDR);
	assign intr_data = 1'b0;

endmodule

`default_nettype wire

//--- hdl/pixel_loader.sv
`default_nettype none

module pixel_loader
	import cnn_load_pkg::*;
#(
	parameter int PIXEL_WORDS = DEF_PIXEL_WORDS
)(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  hit,
	input  logic [MEM_DATA_W-1:0] wr_data,
	output mem_wr_t               mem_wr,
	output logic                  done
);

	logic [MEM_ADDR_W-1:0] count;
	logic                  last;

	assign last = (count == MEM_ADDR_W'(PIXEL_WORDS - 1));

	// wraps after the last pixel so the next image starts at 0
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			count <= '0;
		else if (hit)
		begin
			if (last)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

	always_comb
	begin
		mem_wr.en   = hit;
		mem_wr.addr = count;
		mem_wr.data = wr_data;
	end

	assign done = hit && last;

endmodule

`default_nettype wire

//--- hdl/layer7_bank_mapper.sv
`default_nettype none

module layer7_bank_mapper
	import cnn_load_pkg::*;
#(
	parameter int L7_BANK_DEPTH = DEF_L7_BANK_DEPTH
)(
	input  logic [MEM_ADDR_W-1:0] index,
	output logic [BANK_SEL_W-1:0] bank_sel,
	output logic [MEM_ADDR_W-1:0] offset
);

	// last bank unless a lower boundary catches the index first
	always_comb
	begin
		bank_sel = BANK_SEL_W'(L7_BANKS);
		offset   = index - MEM_ADDR_W'((L7_BANKS - 1) * L7_BANK_DEPTH);
		// walk down so the lowest matching bank is the one kept
		for (int b = L7_BANKS - 2; b >= 0; b--)
		begin
			if (index < MEM_ADDR_W'((b + 1) * L7_BANK_DEPTH))
			begin
				bank_sel = BANK_SEL_W'(b + 1);
				offset   = index - MEM_ADDR_W'(b * L7_BANK_DEPTH);
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/weight_loader.sv
`default_nettype none

module weight_loader
	import cnn_load_pkg::*;
#(
	parameter logic [NUM_WLAYERS-2:0][MEM_ADDR_W-1:0] LAYER_WORDS =
		DEF_LAYER_WORDS[NUM_WLAYERS-2:0],
	parameter int L7_BANK_DEPTH = DEF_L7_BANK_DEPTH
)(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   hit,
	input  logic [MEM_DATA_W-1:0]  wr_data,
	output mem_wr_t                mem_wr,
	output mem_wr_t                l7_mem_wr,
	output logic [BANK_SEL_W-1:0]  l7_bank_sel,
	output logic [NUM_WLAYERS-1:0] layer_done,
	output logic [LAYER_ID_W-1:0]  layer_sel
);

	localparam int L7_WORDS = L7_BANK_DEPTH * L7_BANKS;
	localparam int ST_W     = $clog2(NUM_WLAYERS + 1);

	// states 0..NUM_WLAYERS-1 follow LAYER_IDS, then finish
	localparam logic [ST_W-1:0] ST_L7     = ST_W'(NUM_WLAYERS - 1);
	localparam logic [ST_W-1:0] ST_FINISH = ST_W'(NUM_WLAYERS);

	logic [ST_W-1:0]       state;
	logic [ST_W-1:0]       done_cnt;
	logic [MEM_ADDR_W-1:0] count;
	logic [MEM_ADDR_W-1:0] last_idx;
	logic                  in_l7;
	logic                  write;
	logic                  layer_end;
	logic [BANK_SEL_W-1:0] bank_sel;
	logic [MEM_ADDR_W-1:0] l7_offset;

	assign in_l7     = (state == ST_L7);
	assign write     = hit && (state != ST_FINISH);
	assign layer_end = write && (count == last_idx);

	// terminal index of the current layer
	always_comb
	begin
		last_idx = MEM_ADDR_W'(L7_WORDS - 1);
		for (int i = 0; i < NUM_WLAYERS - 1; i++)
		begin
			if (state == i)
				last_idx = LAYER_WORDS[i] - 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= '0;
			count <= '0;
		end
		else if (layer_end)
		begin
			state <= state + 1'b1;
			count <= '0;
		end
		else if (write)
			count <= count + 1'b1;
	end

	always_comb
	begin
		layer_done = '0;
		if (layer_end)
			layer_done[state] = 1'b1;
	end

	// completed layers, counting the one finishing this cycle
	assign done_cnt = state + ST_W'(layer_end);

	always_comb
	begin
		if (done_cnt == '0)
			layer_sel = '0;
		else
			layer_sel = LAYER_IDS[done_cnt - 1'b1];
	end

	layer7_bank_mapper #(
		.L7_BANK_DEPTH(L7_BANK_DEPTH)
	) layer7_bank_mapper_i (
		.index   (count),
		.bank_sel(bank_sel),
		.offset  (l7_offset)
	);

	always_comb
	begin
		mem_wr.en      = write && !in_l7;
		mem_wr.addr    = count;
		mem_wr.data    = wr_data;
		l7_mem_wr.en   = write && in_l7;
		l7_mem_wr.addr = l7_offset;
		l7_mem_wr.data = wr_data;
	end

	// no bank outside layer 7
	assign l7_bank_sel = in_l7 ? bank_sel : '0;

endmodule

`default_nettype wire

//--- hdl/cnn_load_ctrl.sv
`default_nettype none

module cnn_load_ctrl
	import cnn_bus_pkg::*;
	import cnn_load_pkg::*;
#(
	parameter logic [NUM_WLAYERS-2:0][MEM_ADDR_W-1:0] LAYER_WORDS =
		DEF_LAYER_WORDS[NUM_WLAYERS-2:0],
	parameter int L7_BANK_DEPTH = DEF_L7_BANK_DEPTH,
	parameter int PIXEL_WORDS   = DEF_PIXEL_WORDS
)(
	input  logic                   clk,
	input  logic                   rst,
	input  bus_wr_t                bus,
	input  logic [1:0]             image_set_q,
	output logic                   image_set_we,
	output logic [1:0]             image_set_data,
	output logic                   intr_we,
	output logic                   intr_data,
	output mem_wr_t                pixel_mem_wr,
	output mem_wr_t                weight_mem_wr,
	output mem_wr_t                l7_weight_mem_wr,
	output logic [BANK_SEL_W-1:0]  l7_bank_sel,
	output logic                   pixel_done,
	output logic [NUM_WLAYERS-1:0] layer_done,
	output logic [LAYER_ID_W-1:0]  layer_sel
);

	logic                  pixel_hit;
	logic                  weight_hit;
	logic [MEM_DATA_W-1:0] wr_data;

	bus_write_decoder bus_write_decoder_i (
		.bus           (bus),
		.image_set_q   (image_set_q),
		.pixel_hit     (pixel_hit),
		.weight_hit    (weight_hit),
		.wr_data       (wr_data),
		.image_set_we  (image_set_we),
		.image_set_data(image_set_data),
		.intr_we       (intr_we),
		.intr_data     (intr_data)
	);

	pixel_loader #(
		.PIXEL_WORDS(PIXEL_WORDS)
	) pixel_loader_i (
		.clk    (clk),
		.rst    (rst),
		.hit    (pixel_hit),
		.wr_data(wr_data),
		.mem_wr (pixel_mem_wr),
		.done   (pixel_done)
	);

	weight_loader #(
		.LAYER_WORDS  (LAYER_WORDS),
		.L7_BANK_DEPTH(L7_BANK_DEPTH)
	) weight_loader_i (
		.clk        (clk),
		.rst        (rst),
		.hit        (weight_hit),
		.wr_data    (wr_data),
		.mem_wr     (weight_mem_wr),
		.l7_mem_wr  (l7_weight_mem_wr),
		.l7_bank_sel(l7_bank_sel),
		.layer_done (layer_done),
		.layer_sel  (layer_sel)
	);

endmodule

`default_nettype wire

//--- test/tb_cnn_load_ctrl.sv
`default_nettype none

module tb_cnn_load_ctrl
	import cnn_bus_pkg::*;
	import cnn_load_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD          = 20;
	localparam int RESET_CYCLES    = 16;
	localparam int DUT_L7_DEPTH    = 2;
	localparam int DUT_PIXEL_WORDS = 8;
	localparam logic [NUM_WLAYERS-2:0][MEM_ADDR_W-1:0] DUT_LAYER_WORDS = {
		16'd6, 16'd6, 16'd6, 16'd4
	};
	// registers 4, pixels 10, layers 1 to 5 22, layer 7 10, finish 4
	localparam int PLANNED_WRITES = 50;

	logic                   clk;
	logic                   rst;
	bus_wr_t                bus;
	logic [1:0]             image_set_q;
	logic                   image_set_we;
	logic [1:0]             image_set_data;
	logic                   intr_we;
	logic                   intr_data;
	mem_wr_t                pixel_mem_wr;
	mem_wr_t                weight_mem_wr;
	mem_wr_t                l7_weight_mem_wr;
	logic [BANK_SEL_W-1:0]  l7_bank_sel;
	logic                   pixel_done;
	logic [NUM_WLAYERS-1:0] layer_done;
	logic [LAYER_ID_W-1:0]  layer_sel;

	int errors = 0;
	int checks = 0;
	// reference state: next pixel index, current layer slot and word
	int pixel_count = 0;
	int wlayer = 0;
	int wcount = 0;

	cnn_load_ctrl #(
		.LAYER_WORDS  (DUT_LAYER_WORDS),
		.L7_BANK_DEPTH(DUT_L7_DEPTH),
		.PIXEL_WORDS  (DUT_PIXEL_WORDS)
	) cnn_load_ctrl_i (
		.clk             (clk),
		.rst             (rst),
		.bus             (bus),
		.image_set_q     (image_set_q),
		.image_set_we    (image_set_we),
		.image_set_data  (image_set_data),
		.intr_we         (intr_we),
		.intr_data       (intr_data),
		.pixel_mem_wr    (pixel_mem_wr),
		.weight_mem_wr   (weight_mem_wr),
		.l7_weight_mem_wr(l7_weight_mem_wr),
		.l7_bank_sel     (l7_bank_sel),
		.pixel_done      (pixel_done),
		.layer_done      (layer_done),
		.layer_sel       (layer_sel)
	);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(PERIOD * (PLANNED_WRITES * 4 + RESET_CYCLES));
		$display("watchdog expired before the tests completed");
		$display("TEST FAIL");
		$finish;
	end

	function automatic int words_of(input int slot);
		if (slot == 0)
			return 4;
		else if (slot == NUM_WLAYERS - 1)
			return DUT_L7_DEPTH * L7_BANKS;
		return 6;
	endfunction

	// load order 1, 2, 4, 5, 7
	function automatic int id_of(input int slot);
		case (slot)
			0: return 1;
			1: return 2;
			2: return 4;
			3: return 5;
			default: return 7;
		endcase
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// one bus word, outputs sampled mid-cycle
	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		bus.awaddr  <= addr;
		bus.awvalid <= 1'b1;
		bus.wdata   <= data;
		bus.wvalid  <= 1'b1;
		@(negedge clk);
	endtask

	task automatic idle_check();
		@(posedge clk);
		bus <= '0;
		@(negedge clk);
		check(pixel_mem_wr.en | weight_mem_wr.en | l7_weight_mem_wr.en, 0, "memory write idle");
		check(image_set_we | intr_we, 0, "register write idle");
		check(pixel_done, 0, "pixel_done idle");
		check(layer_done, 0, "layer_done idle");
		check(layer_sel, (wlayer == 0) ? 0 : id_of(wlayer - 1), "layer_sel hold");
	endtask

	task automatic pixel_step();
		logic [31:0] data;
		logic [15:0] low;
		logic        last;
		data = $urandom;
		low  = $urandom;
		last = (pixel_count == DUT_PIXEL_WORDS - 1);
		bus_write({PIXEL_REGION, low}, data);
		check(pixel_mem_wr.en, 1, "pixel write enable");
		check(pixel_mem_wr.addr, pixel_count, "pixel address");
		check(pixel_mem_wr.data, data[15:0], "pixel data");
		check(weight_mem_wr.en | l7_weight_mem_wr.en, 0, "weight write on pixel hit");
		if (last && !pixel_done)
		begin
			errors++;
			$display("pixel_done pulse missing on the last pixel at %0t", $time);
		end
		else
			check(pixel_done, last, "pixel_done");
		pixel_count = last ? 0 : pixel_count + 1;
	endtask

	task automatic weight_step();
		logic [31:0]            data;
		logic [15:0]            low;
		logic                   last;
		logic [NUM_WLAYERS-1:0] exp_done;
		data = $urandom;
		low  = $urandom;
		bus_write({WEIGHT_REGION, low}, data);
		check(pixel_mem_wr.en, 0, "pixel write on weight hit");
		if (wlayer == NUM_WLAYERS)
		begin
			check(weight_mem_wr.en | l7_weight_mem_wr.en, 0, "write after finish");
			check(layer_done, 0, "layer_done after finish");
			check(layer_sel, 7, "layer_sel after finish");
			return;
		end
		last     = (wcount == words_of(wlayer) - 1);
		exp_done = '0;
		exp_done[wlayer] = last;
		if (wlayer == NUM_WLAYERS - 1)
		begin
			check(weight_mem_wr.en, 0, "layer 7 word on weight port");
			check(l7_weight_mem_wr.en, 1, "layer 7 write enable");
			check(l7_weight_mem_wr.addr, wcount % DUT_L7_DEPTH, "layer 7 bank address");
			check(l7_weight_mem_wr.data, data[15:0], "layer 7 data");
			check(l7_bank_sel, wcount / DUT_L7_DEPTH + 1, "layer 7 bank select");
		end
		else
		begin
			check(l7_weight_mem_wr.en, 0, "layer 7 port outside layer 7");
			check(weight_mem_wr.en, 1, "weight write enable");
			check(weight_mem_wr.addr, wcount, "weight address");
			check(weight_mem_wr.data, data[15:0], "weight data");
			check(l7_bank_sel, 0, "bank select outside layer 7");
		end
		if (last && !layer_done[wlayer])
		begin
			errors++;
			$display("layer %0d done pulse missing at %0t", id_of(wlayer), $time);
		end
		else
			check(layer_done, exp_done, "layer_done");
		if (last)
		begin
			wlayer++;
			wcount = 0;
		end
		else
			wcount++;
		check(layer_sel, (wlayer == 0) ? 0 : id_of(wlayer - 1), "layer_sel");
	endtask

	task automatic register_test();
		logic [31:0] data;
		data = $urandom | 32'h1;
		bus_write(IMAGE_SET_ADDR, data);
		check(image_set_we, 1, "image set write enable");
		check(image_set_data, data[1:0], "image set data");
		check(intr_we, 0, "interrupt on image set write");
		// nonzero register and no hit gives the auto-clear
		@(posedge clk);
		bus         <= '0;
		image_set_q <= 2'b10;
		@(negedge clk);
		check(image_set_we, 1, "auto-clear enable");
		check(image_set_data, 0, "auto-clear data");
		bus_write(IMAGE_SET_ADDR, data);
		check(image_set_data, data[1:0], "cpu write over auto-clear");
		@(posedge clk);
		bus         <= '0;
		image_set_q <= 2'b00;
		bus_write(INTR_ADDR, $urandom);
		check(intr_we, 1, "interrupt write enable");
		check(intr_data, 0, "interrupt data");
		check(image_set_we, 0, "image set on interrupt write");
		bus_write(32'h1234_5678, $urandom);
		check(image_set_we | intr_we, 0, "register write on unmapped address");
		check(pixel_mem_wr.en | weight_mem_wr.en | l7_weight_mem_wr.en, 0, "unmapped write");
		idle_check();
	endtask

	task automatic pixel_test();
		for (int i = 0; i <= DUT_PIXEL_WORDS; i++)
		begin
			pixel_step();
			if (i % 2 == 0)
				idle_check();
			if (i == 3)
				weight_step();
		end
		idle_check();
	endtask

	task automatic weight_test();
		while (wlayer < NUM_WLAYERS - 1)
		begin
			weight_step();
			if (wlayer == 1 && wcount == 2)
				pixel_step();
			if (wcount == 0)
				idle_check();
		end
	endtask

	task automatic layer7_test();
		while (wlayer < NUM_WLAYERS)
			weight_step();
		idle_check();
	endtask

	task automatic finish_test();
		repeat (3) weight_step();
		pixel_step();
		idle_check();
	endtask

	initial
	begin
		void'($urandom(32'h783f));
		rst         = 1'b1;
		bus         = '0;
		image_set_q = 2'b00;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		idle_check();
		register_test();
		pixel_test();
		weight_test();
		layer7_test();
		finish_test();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
hdl/cnn_bus_pkg.sv
hdl/cnn_load_pkg.sv
hdl/bus_write_decoder.sv
hdl/pixel_loader.sv
hdl/layer7_bank_mapper.sv
hdl/weight_loader.sv
hdl/cnn_load_ctrl.sv
test/tb_cnn_load_ctrl.sv

//--- Bender.yml
package:
  name: cnn_load_ctrl

sources:
  - hdl/cnn_bus_pkg.sv
  - hdl/cnn_load_pkg.sv
  - hdl/bus_write_decoder.sv
  - hdl/pixel_loader.sv
  - hdl/layer7_bank_mapper.sv
  - hdl/weight_loader.sv
  - hdl/cnn_load_ctrl.sv
  - target: simulation
    files:
      - test/tb_cnn_load_ctrl.sv
